// File: src.f
+incdir+source
source/cpu_pkg.sv
source/cpu_ctrl_if.sv
source/cpu_alu.sv
source/cpu_sequencer.sv
source/cpu_datapath.sv
source/cpu_top.sv
verif/tb_clock.sv
verif/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module tb_cpu \
    -Mdir obj_dir -o tb_cpu
./obj_dir/tb_cpu | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log
then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: verif/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module tb_cpu;
    import cpu_pkg::*;

    logic    clock;
    logic    reset;
    logic    enable;
    byte_t   data_in;
    addr_t   address;
    byte_t   data_out;
    logic    write_en;
    logic    sync;
    opcode_t debug_opcode;
    addr_t   debug_pc;
    byte_t   debug_a;
    byte_t   debug_x;
    byte_t   debug_y;
    byte_t   debug_p;

    byte_t mem [0:65535];     // Bus memory seen by the DUT
    byte_t ref_mem [0:65535]; // Model's own memory, updated at instruction level

    // Every instruction the core keeps, except JMP which closes the program
    opcode_t op_table [0:31] = '{
        8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9,        // Group one #imm
        8'h05, 8'h25, 8'h45, 8'h65, 8'h85, 8'hA5, 8'hC5, 8'hE5, // Group one zp
        8'hA0, 8'hA2, 8'hA4, 8'hA6, 8'h84, 8'h86,               // LDY LDX STY STX
        8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88, // Transfers, inc/dec
        8'h18, 8'h38, 8'hEA                                     // CLC SEC NOP
    };

    integer  seed = 32'hb5af6303;
    addr_t   restart_pc = `CPU_RESET_PC;
    addr_t   model_pc;
    byte_t   m_a, m_x, m_y;
    logic    m_n, m_v, m_z, m_c;
    byte_t   exp_a, exp_x, exp_y, exp_p; // Model state before the fetched instruction
    opcode_t exp_opcode;
    addr_t   exp_store_addr;
    byte_t   exp_store_data;
    logic    store_pending, check_pending, finished, timed_out;
    int      pass_count, fail_count, test_errors, passes, n_instr, limit, cycles, pos;
    logic [4:0] idx;

    tb_clock clock0 (.clock(clock), .reset(reset));

    cpu_top dut0
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_en     (write_en),
        .sync         (sync),
        .debug_opcode (debug_opcode),
        .debug_pc     (debug_pc),
        .debug_a      (debug_a),
        .debug_x      (debug_x),
        .debug_y      (debug_y),
        .debug_p      (debug_p)
    );

    assign data_in = mem[address]; // Combinational read

    // Random back-pressure
    initial
    begin
        enable <= 1'b0;
        forever
        begin
            @(posedge clock);
            enable <= (2'($random(seed)) != 2'b00); // High three cycles in four
        end
    end

    function automatic addr_t instr_length(input opcode_t op);
        case (op)
            8'h4C:
                instr_length = 16'h0003;
            8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h18, 8'h38, 8'hEA:
                instr_length = 16'h0001; // Implied
            default:
                instr_length = 16'h0002;
        endcase
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            fail_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            fail_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
        if (got !== exp)
        begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            fail_count++;
            test_errors++;
        end
        else
            pass_count++;
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        fail_count++;
        test_errors++;
    endtask

    task automatic set_nz(input byte_t value);
        m_n = value[7];
        m_z = (value == 8'h00);
    endtask

    task automatic load_a(input byte_t value);
        m_a = value;
        set_nz(value);
    endtask

    task automatic load_x(input byte_t value);
        m_x = value;
        set_nz(value);
    endtask

    task automatic load_y(input byte_t value);
        m_y = value;
        set_nz(value);
    endtask

    // Binary add; SBC and CMP pass the complemented operand
    task automatic add_carry(input byte_t addend, input logic carry, input logic keep_a);
        logic [8:0] sum;
        sum = {1'b0, m_a} + {1'b0, addend} + {8'h00, carry};
        m_c = sum[8];
        if (keep_a)
            set_nz(m_a); // Compare keeps A and V, N and Z follow A
        else
        begin
            m_v = (m_a[7] == addend[7]) && (sum[7] != m_a[7]); // Sign flip of like signs
            load_a(sum[7:0]);
        end
    endtask

    task automatic model_store(input addr_t addr, input byte_t value);
        ref_mem[addr] = value;
        exp_store_addr = addr;
        exp_store_data = value;
        store_pending = 1'b1; // Expected on the bus before the next fetch
    endtask

    // One whole instruction at model_pc
    task automatic exec_instr();
        opcode_t op;
        byte_t   opnd;
        byte_t   operand;
        addr_t   zp_addr;
        op      = ref_mem[model_pc];
        opnd    = ref_mem[model_pc + 16'h0001];
        zp_addr = {`CPU_ZP_PAGE, opnd};
        operand = (op[4:2] == 3'b001) ? ref_mem[zp_addr] : opnd; // Zero page or immediate
        if (op[1:0] == 2'b01)
        begin
            case (op[7:5])
                3'd0:    load_a(m_a | operand);            // ORA
                3'd1:    load_a(m_a & operand);            // AND
                3'd2:    load_a(m_a ^ operand);            // EOR
                3'd3:    add_carry(operand, m_c, 1'b0);    // ADC
                3'd4:    model_store(zp_addr, m_a);        // STA
                3'd5:    load_a(operand);                  // LDA
                3'd6:    add_carry(~operand, 1'b1, 1'b1);  // CMP
                default: add_carry(~operand, m_c, 1'b0);   // SBC
            endcase
        end
        else
        begin
            case (op)
                8'hA0, 8'hA4: load_y(operand);
                8'hA2, 8'hA6: load_x(operand);
                8'h84:        model_store(zp_addr, m_y);
                8'h86:        model_store(zp_addr, m_x);
                8'hAA:        load_x(m_a);
                8'hA8:        load_y(m_a);
                8'h8A:        load_a(m_x);
                8'h98:        load_a(m_y);
                8'hE8:        load_x(m_x + 8'h01);
                8'hC8:        load_y(m_y + 8'h01);
                8'hCA:        load_x(m_x - 8'h01);
                8'h88:        load_y(m_y - 8'h01);
                8'h18:        m_c = 1'b0;
                8'h38:        m_c = 1'b1;
                default:      ; // NOP, JMP
            endcase
        end
        if (op == 8'h4C)
            model_pc = {ref_mem[model_pc + 16'h0002], opnd};
        else
            model_pc = model_pc + instr_length(op);
    endtask

    initial
    begin
        // Zero page random, program region NOP before the draw
        for (int i = 0; i < 256; i++)
        begin
            ref_mem[addr_t'(i)] = byte_t'($random(seed));
            ref_mem[restart_pc + addr_t'(i)] = `CPU_NOP_OPCODE;
        end
        pos = 0;
        n_instr = 1; // Closing JMP
        while (pos < 252)
        begin
            idx = 5'($random(seed));
            ref_mem[restart_pc + addr_t'(pos)] = op_table[idx];
            ref_mem[restart_pc + addr_t'(pos + 1)] = byte_t'($random(seed)); // Operand
            pos = pos + int'(instr_length(op_table[idx]));
            n_instr++;
        end
        ref_mem[restart_pc + addr_t'(pos)] = 8'h4C;
        ref_mem[restart_pc + addr_t'(pos + 1)] = restart_pc[7:0];
        ref_mem[restart_pc + addr_t'(pos + 2)] = restart_pc[15:8];
        for (int i = 0; i < 32'h0300; i++)
            mem[addr_t'(i)] <= ref_mem[addr_t'(i)];

        model_pc = restart_pc;
        {m_a, m_x, m_y} = 24'h000000;
        {m_n, m_v, m_z, m_c} = 4'b0000;
        {store_pending, check_pending, finished, timed_out} = 4'b0000;
        pass_count = 0;
        fail_count = 0;
        test_errors = 0;
        passes = 0;
        cycles = 0;
        limit = n_instr * 3 * 2 * 2 + 100; // Slowest op, enable duty, two passes

        do
            @(posedge clock);
        while (reset);

        check_addr("debug_pc", debug_pc, restart_pc);
        check_opcode("debug_opcode", debug_opcode, `CPU_NOP_OPCODE);
        check_byte("debug_a", debug_a, 8'h00);
        check_byte("debug_x", debug_x, 8'h00);
        check_byte("debug_y", debug_y, 8'h00);
        check_byte("debug_p", debug_p, 8'h30); // Only the fixed ones
        if (write_en !== 1'b0)
            report_error("write_en is not low after reset");
        $display("Test 1 reset values: %0d errors", test_errors);
        test_errors = 0;

        while (!finished && !timed_out)
        begin
            if (enable && write_en)
                mem[address] <= data_out; // Memory model write
            if (check_pending)
            begin
                // Previous instruction written back during this fetch
                check_byte("debug_a", debug_a, exp_a);
                check_byte("debug_x", debug_x, exp_x);
                check_byte("debug_y", debug_y, exp_y);
                check_byte("debug_p", debug_p, exp_p);
                check_opcode("debug_opcode", debug_opcode, exp_opcode);
                check_pending = 1'b0;
                finished = (passes == 3);
                if (finished)
                    $display("Test 3 program pass 2: %0d errors", test_errors);
            end
            if (enable && write_en)
            begin
                if (store_pending)
                begin
                    check_addr("address", address, exp_store_addr);
                    check_byte("data_out", data_out, exp_store_data);
                    store_pending = 1'b0;
                end
                else
                    report_error("write_en high outside a zero-page store");
            end
            if (enable && sync && !finished)
            begin
                if (store_pending)
                    report_error("zero-page store never reached the bus");
                store_pending = 1'b0;
                check_addr("debug_pc", debug_pc, model_pc);
                if (model_pc == restart_pc)
                    passes++;
                if (model_pc == restart_pc && passes == 2)
                begin
                    $display("Test 2 program pass 1: %0d errors", test_errors);
                    test_errors = 0;
                end
                exp_a = m_a;
                exp_x = m_x;
                exp_y = m_y;
                exp_p = {m_n, m_v, 4'b1100, m_z, m_c};
                exp_opcode = ref_mem[model_pc];
                if (passes < 3)
                    exec_instr();
                check_pending = 1'b1;
            end
            if (!finished)
            begin
                @(posedge clock);
                cycles++;
                timed_out = (cycles > limit);
            end
        end

        if (timed_out)
            $display("Timeout: two program passes did not finish within %0d cycles", limit);
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (timed_out || fail_count != 0)
            $display("*** TEST FAILED ***");
        else
            $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
    output logic clock,
    output logic reset
);

    // 4 ns period, first rising edge at 2 ns
    initial
    begin
        clock = 1'b0;
        forever
            #2 clock = ~clock;
    end

    initial
    begin
        reset <= 1'b1;
        repeat (5)
            @(posedge clock); // Five cycles in reset
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top
(
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,       // Clock enable, low stalls the core
    input  cpu_pkg::byte_t   data_in,
    output cpu_pkg::addr_t   address,
    output cpu_pkg::byte_t   data_out,
    output logic             write_en,
    output logic             sync,         // Opcode fetch cycle
    output cpu_pkg::opcode_t debug_opcode,
    output cpu_pkg::addr_t   debug_pc,
    output cpu_pkg::byte_t   debug_a,
    output cpu_pkg::byte_t   debug_x,
    output cpu_pkg::byte_t   debug_y,
    output cpu_pkg::byte_t   debug_p
);

    // Per-cycle control word
    cpu_ctrl_if ctrl ();

    cpu_sequencer sequencer0
    (
        .clock   (clock),
        .reset   (reset),
        .enable  (enable),
        .data_in (data_in),
        .ctrl    (ctrl.seq),
        .sync    (sync),
        .opcode  (debug_opcode)
    );

    cpu_datapath datapath0
    (
        .clock    (clock),
        .reset    (reset),
        .enable   (enable),
        .ctrl     (ctrl.dp),
        .data_in  (data_in),
        .address  (address),
        .data_out (data_out),
        .write_en (write_en),
        .pc       (debug_pc),
        .a        (debug_a),
        .x        (debug_x),
        .y        (debug_y),
        .p        (debug_p)
    );

endmodule

`default_nettype wire

// File: source/cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_datapath
(
    input  logic           clock,
    input  logic           reset,
    input  logic           enable,
    cpu_ctrl_if.dp         ctrl,
    input  cpu_pkg::byte_t data_in,  // Raw bus byte
    output cpu_pkg::addr_t address,
    output cpu_pkg::byte_t data_out,
    output logic           write_en,
    output cpu_pkg::addr_t pc,
    output cpu_pkg::byte_t a,
    output cpu_pkg::byte_t x,
    output cpu_pkg::byte_t y,
    output cpu_pkg::byte_t p
);
    import cpu_pkg::*;

    byte_t data_reg; // Last bus byte, read or written
    byte_t bus;      // Internal data bus
    byte_t alu_result;
    logic  alu_c;
    logic  alu_v;
    logic  flag_n;
    logic  flag_v;
    logic  flag_z;
    logic  flag_c;

    // Operands are A and the registered byte
    cpu_alu alu0
    (
        .a      (a),
        .b      (data_reg),
        .c_in   (flag_c),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .c_out  (alu_c),
        .v_out  (alu_v)
    );

    always_comb
    begin
        case (ctrl.db_src)
            DB_DATA_IN: bus = data_reg;
            DB_ALU:     bus = alu_result;
            DB_A:       bus = a;
            DB_X:       bus = x;
            DB_Y:       bus = y;
            DB_X_INC:   bus = x + 8'h01;
            DB_X_DEC:   bus = x - 8'h01;
            DB_Y_INC:   bus = y + 8'h01;
            DB_Y_DEC:   bus = y - 8'h01;
            default:    bus = 8'h00; // Nothing driving
        endcase
    end

    always_comb
    begin
        case (ctrl.addr_src)
            ADDR_ZP: address = {`CPU_ZP_PAGE, data_reg}; // Operand byte as low address
            default: address = pc;
        endcase
    end

    // Store data
    always_comb
    begin
        case (ctrl.wdata_src)
            WDATA_X: data_out = x;
            WDATA_Y: data_out = y;
            default: data_out = a;
        endcase
    end

    assign write_en = ctrl.write_en;

    // N V 1 B D I Z C, with B set and D, I absent
    assign p = {flag_n, flag_v, 1'b1, 1'b1, 1'b0, 1'b0, flag_z, flag_c};

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc     <= `CPU_RESET_PC;
            a      <= 8'h00;
            x      <= 8'h00;
            y      <= 8'h00;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (enable)
        begin
            if (ctrl.pc_load)
                pc <= {data_in, data_reg}; // JMP target, high byte live on the bus
            else if (ctrl.pc_inc)
                pc <= pc + 16'h0001;

            if (ctrl.load_a)
                a <= bus;
            if (ctrl.load_x)
                x <= bus;
            if (ctrl.load_y)
                y <= bus;

            if (ctrl.set_nz)
            begin
                flag_n <= bus[7];
                flag_z <= (bus == 8'h00);
            end

            if (ctrl.set_c_op)
                flag_c <= ctrl.alu_op[0]; // Opcode bit 5, CLC vs SEC
            else if (ctrl.set_cv_alu)
                flag_c <= alu_c;

            if (ctrl.set_cv_alu && (ctrl.alu_op inside {ALU_ADC, ALU_SBC}))
                flag_v <= alu_v; // CMP leaves V alone
        end
    end

    // After a write the register reflects what went out
    always_ff @(posedge clock)
    begin
        if (enable)
            data_reg <= ctrl.write_en ? data_out : data_in;
    end

endmodule

`default_nettype wire

// File: source/cpu_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_sequencer
(
    input  logic             clock,
    input  logic             reset,
    input  logic             enable,
    input  cpu_pkg::byte_t   data_in, // Raw bus byte, opcode in FETCH
    cpu_ctrl_if.seq          ctrl,
    output logic             sync,
    output cpu_pkg::opcode_t opcode
);
    import cpu_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    db_src_t    wb_db_src;  // Bus source for the write-back
    wdata_src_t store_src;

    // Anything outside the kept subset becomes a NOP
    function automatic logic is_supported(input opcode_t op);
        case (op) inside
            8'h89:                        is_supported = 1'b0; // No STA immediate
            8'b???_010_01, 8'b???_001_01: is_supported = 1'b1; // Group one, #imm and zp
            8'hA0, 8'hA2, 8'hA4, 8'hA6:   is_supported = 1'b1; // LDY/LDX
            8'h84, 8'h86:                 is_supported = 1'b1; // STY/STX zp
            8'hAA, 8'hA8, 8'h8A, 8'h98:   is_supported = 1'b1; // Transfers
            8'hE8, 8'hC8, 8'hCA, 8'h88:   is_supported = 1'b1; // INX INY DEX DEY
            8'h18, 8'h38, 8'hEA, 8'h4C:   is_supported = 1'b1; // CLC SEC NOP JMP
            default:                      is_supported = 1'b0;
        endcase
    endfunction

    // Addressing class
    wire logic op_group1    = opcode[1:0] == 2'b01;
    wire logic op_implied   = opcode ==? 8'b???_?10_?0; // One byte
    wire logic op_zero_page = opcode[4:2] == 3'b001;
    wire logic op_jmp       = opcode == 8'h4C;
    wire logic op_store     = op_zero_page & (opcode[7:5] == 3'b100); // STA/STX/STY

    // Write-back class of the instruction in the opcode register
    wire logic op_arith   = op_group1 & (opcode[7:5] != 3'b100); // All but STA
    wire logic op_cmp     = op_group1 & (opcode[7:5] == 3'b110);
    wire logic op_carry   = op_arith & (opcode[7:5] inside {3'b011, 3'b110, 3'b111});
    wire logic op_ldx     = opcode ==? 8'b101_00?_10;
    wire logic op_ldy     = opcode ==? 8'b101_00?_00;
    wire logic op_tax     = opcode == 8'hAA;
    wire logic op_tay     = opcode == 8'hA8;
    wire logic op_txa     = opcode == 8'h8A;
    wire logic op_tya     = opcode == 8'h98;
    wire logic op_inx     = opcode == 8'hE8;
    wire logic op_iny     = opcode == 8'hC8;
    wire logic op_dex     = opcode == 8'hCA;
    wire logic op_dey     = opcode == 8'h88;
    wire logic op_clc_sec = opcode ==? 8'b00?_110_00;

    wire logic wb_load_a = (op_arith & ~op_cmp) | op_txa | op_tya;
    wire logic wb_load_x = op_ldx | op_tax | op_inx | op_dex;
    wire logic wb_load_y = op_ldy | op_tay | op_iny | op_dey;

    always_comb
    begin
        if (op_arith)
            wb_db_src = DB_ALU;       // LDA too, ALU passes b
        else if (op_ldx | op_ldy)
            wb_db_src = DB_DATA_IN;
        else if (op_tax | op_tay)
            wb_db_src = DB_A;
        else if (op_txa)
            wb_db_src = DB_X;
        else if (op_tya)
            wb_db_src = DB_Y;
        else if (op_inx)
            wb_db_src = DB_X_INC;
        else if (op_dex)
            wb_db_src = DB_X_DEC;
        else if (op_iny)
            wb_db_src = DB_Y_INC;
        else if (op_dey)
            wb_db_src = DB_Y_DEC;
        else
            wb_db_src = DB_NONE;
    end

    // Store register from opcode bits 1..0
    always_comb
    begin
        case (opcode[1:0])
            2'b00:   store_src = WDATA_Y;
            2'b10:   store_src = WDATA_X;
            default: store_src = WDATA_A;
        endcase
    end

    always_comb
    begin
        // Quiet control word unless a state asks for more
        next_state      = FETCH;
        ctrl.pc_inc     = 1'b0;
        ctrl.pc_load    = 1'b0;
        ctrl.addr_src   = ADDR_PC;
        ctrl.write_en   = 1'b0;
        ctrl.wdata_src  = store_src;
        ctrl.db_src     = DB_NONE;
        ctrl.alu_op     = alu_op_t'(opcode[7:5]);
        ctrl.load_a     = 1'b0;
        ctrl.load_x     = 1'b0;
        ctrl.load_y     = 1'b0;
        ctrl.set_nz     = 1'b0;
        ctrl.set_cv_alu = 1'b0;
        ctrl.set_c_op   = 1'b0;

        case (state)
            FETCH:
            begin
                // Opcode read overlaps the previous instruction's write-back
                next_state      = OPERAND;
                ctrl.pc_inc     = 1'b1;
                ctrl.db_src     = wb_db_src;
                ctrl.load_a     = wb_load_a;
                ctrl.load_x     = wb_load_x;
                ctrl.load_y     = wb_load_y;
                ctrl.set_nz     = wb_load_a | wb_load_x | wb_load_y | op_cmp;
                ctrl.set_cv_alu = op_carry;
                ctrl.set_c_op   = op_clc_sec;
            end
            OPERAND:
            begin
                ctrl.pc_inc = ~op_implied; // Implied ops reread the next opcode
                if (op_zero_page)
                    next_state = ZP_ACCESS;
                else if (op_jmp)
                    next_state = JMP_HIGH;
            end
            ZP_ACCESS:
            begin
                ctrl.addr_src = ADDR_ZP;
                ctrl.write_en = op_store;
            end
            JMP_HIGH:
            begin
                ctrl.pc_load = 1'b1; // Low byte already registered
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= FETCH;
            opcode <= `CPU_NOP_OPCODE;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state == FETCH)
                opcode <= is_supported(data_in) ? data_in : `CPU_NOP_OPCODE;
        end
    end

    assign sync = (state == FETCH);

endmodule

`default_nettype wire

// File: source/cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_alu
(
    input  cpu_pkg::byte_t  a,      // Accumulator
    input  cpu_pkg::byte_t  b,      // Operand byte
    input  logic            c_in,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::byte_t  result,
    output logic            c_out,
    output logic            v_out
);
    import cpu_pkg::*;

    byte_t      addend;
    logic       carry_in;
    logic [8:0] sum;

    // CMP and SBC subtract by adding ~b
    assign addend = op[2] ? ~b : b;

    // CMP ignores the C flag and always subtracts exactly
    assign carry_in = (op == ALU_CMP) | c_in;

    assign sum = {1'b0, a} + {1'b0, addend} + {8'h00, carry_in};

    always_comb
    begin
        case (op)
            ALU_ORA: result = a | b;
            ALU_AND: result = a & b;
            ALU_EOR: result = a ^ b;
            ALU_ADC: result = sum[7:0];
            ALU_LDA: result = b;
            ALU_CMP: result = a;     // A unchanged, carry only
            ALU_SBC: result = sum[7:0];
            default: result = 8'h00; // STA never reaches the bus
        endcase
    end

    assign c_out = sum[8];

    // Signed overflow, both inputs agree in sign and the sum differs
    assign v_out = (a[7] ^ sum[7]) & (addend[7] ^ sum[7]);

endmodule

`default_nettype wire

// File: source/cpu_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cpu_ctrl_if;
    import cpu_pkg::*;

    logic       pc_inc;     // PC + 1
    logic       pc_load;    // PC from {input byte, data-in register}
    addr_src_t  addr_src;
    logic       write_en;   // Bus write this cycle
    wdata_src_t wdata_src;
    db_src_t    db_src;
    alu_op_t    alu_op;     // Also carries opcode bit 5 for CLC/SEC
    logic       load_a;
    logic       load_x;
    logic       load_y;
    logic       set_nz;     // N and Z from the internal bus
    logic       set_cv_alu; // C from ALU, V too for ADC/SBC
    logic       set_c_op;   // C from opcode bit 5

    // Sequencer side drives the whole control word
    modport seq (
        output pc_inc, pc_load, addr_src, write_en, wdata_src, db_src, alu_op,
        output load_a, load_x, load_y, set_nz, set_cv_alu, set_c_op
    );

    // Datapath only consumes it
    modport dp (
        input pc_inc, pc_load, addr_src, write_en, wdata_src, db_src, alu_op,
        input load_a, load_x, load_y, set_nz, set_cv_alu, set_c_op
    );

endinterface

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;   // Data byte, A/X/Y/P
    typedef logic [15:0] addr_t;   // Bus address, PC
    typedef logic [7:0]  opcode_t; // Instruction register

    // Cycle within the instruction
    typedef enum logic [1:0] {
        FETCH,      // Opcode read, write-back of previous instruction
        OPERAND,    // Second byte, dummy read for implied ops
        ZP_ACCESS,  // Zero-page read or write
        JMP_HIGH    // High byte of the JMP target
    } seq_state_t;

    // Group-one operation, straight from opcode bits 7..5
    typedef enum logic [2:0] {
        ALU_ORA, ALU_AND, ALU_EOR, ALU_ADC,
        ALU_STA, ALU_LDA, ALU_CMP, ALU_SBC
    } alu_op_t;

    // Internal data bus source
    typedef enum logic [3:0] {
        DB_NONE, DB_DATA_IN, DB_ALU,
        DB_A, DB_X, DB_Y,
        DB_X_INC, DB_X_DEC, DB_Y_INC, DB_Y_DEC
    } db_src_t;

    typedef enum logic [1:0] {
        ADDR_PC,     // Instruction stream
        ADDR_ZP,     // Zero page, low byte from data-in register
        ADDR_VECTOR  // Fixed restart address
    } addr_src_t;

    // Register driven onto data_out for a store
    typedef enum logic [1:0] {WDATA_A, WDATA_X, WDATA_Y} wdata_src_t;

endpackage

`default_nettype wire

// File: source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// PC loaded on reset; the first opcode fetch comes from here
`define CPU_RESET_PC 16'h0200

// High address byte for every zero-page access
`define CPU_ZP_PAGE 8'h00

// One-byte, two-cycle NOP, also stands in for any opcode the core lacks
`define CPU_NOP_OPCODE 8'hEA

`endif
